//--- Bender.yml
package:
  name: wrr_rank

sources:
  - src/wrr_pkg.sv
  - src/wrr_flow_table.sv
  - src/wrr_rank_calc.sv
  - src/wrr_weight_cfg.sv
  - src/wrr_top.sv
  - target: simulation
    files:
      - bench/wrr_props.sv
      - bench/wrr_tb.sv

//--- bench/wrr_patterns.txt
# op test a b c d e exp, all hex but test. P/N/Q: a port map, b class. N: c count, d random class
# Q adds feedback c port, d round, e ovf. F: a port, b round, c ovf. W/B: a write index, b weight
# B also reads index c. R: a index. exp is the rank or the CPU value
R 1 00 0 0 0 0 100
R 1 45 0 0 0 0 100
R 1 9f 0 0 0 0 100
W 2 03 3 0 0 0 0
P 2 01 3 0 0 0 3
P 2 01 3 0 0 0 3
P 2 01 3 0 0 0 3
P 2 01 3 0 0 0 23
R 2 03 0 0 0 0 10301
N 3 04 2 8 0 0 0
P 3 04 2 0 0 0 10022
F 3 1 7 3 0 0 0
P 3 04 2 0 0 0 300e2
P 3 04 2 0 0 0 22
R 3 22 0 0 0 0 10101
P 4 01 9 0 0 0 9
P 4 04 9 0 0 0 300e9
P 4 10 9 0 0 0 9
P 4 40 9 0 0 0 9
P 4 02 9 0 0 0 9
P 4 00 9 0 0 0 29
R 4 29 0 0 0 0 18070101
R 4 89 0 0 0 0 10101
R 4 0a 0 0 0 0 100
N 5 10 4 7 0 0 0
N 5 01 0 6 1 0 0
F 5 2 3 0 0 0 0
Q 5 10 7 2 5 0 a7
R 5 44 0 0 0 0 60101
R 5 47 0 0 0 0 50101
R 5 50 0 0 0 0 50100
R 5 69 0 0 0 0 101
B 6 50 2 44 0 0 0
R 6 50 0 0 0 0 50200
P 6 10 10 0 0 0 b0
P 6 10 10 0 0 0 b0
P 6 10 10 0 0 0 d0

//--- bench/wrr_props.sv
`timescale 1ns/1ps

module wrr_props
(
   input logic clk_cp,
   input logic rst,
   input logic pkt_valid_i,
   input logic cpu_wr_i,
   input logic cpu_rd_i,
   input logic rank_valid_o,
   input logic cpu_valid_o
);

   int fail_count = 0;   // Failed assertions so far

   ////////////////////////////////////////////////////////////
   // Output timing
   ////////////////////////////////////////////////////////////

   rank_follows_pkt : assert property (@(posedge clk_cp) disable iff (!rst)
      $past(rst) |-> rank_valid_o == $past(pkt_valid_i))
   else
   begin
      $error("rank_valid_o did not follow pkt_valid_i by one cycle");
      fail_count++;
   end

   // Write and read share one response
   cpu_follows_req : assert property (@(posedge clk_cp) disable iff (!rst)
      $past(rst) |-> cpu_valid_o == $past(cpu_wr_i || cpu_rd_i))
   else
   begin
      $error("cpu_valid_o did not follow the CPU request by one cycle");
      fail_count++;
   end

   quiet_after_reset : assert property (@(posedge clk_cp)
      !rst |=> !rank_valid_o && !cpu_valid_o)
   else
   begin
      $error("A valid output was high in the cycle after reset");
      fail_count++;
   end

endmodule

bind wrr_top wrr_props props_inst
(
   .clk_cp       (clk_cp),
   .rst          (rst),
   .pkt_valid_i  (pkt_valid_i),
   .cpu_wr_i     (cpu_wr_i),
   .cpu_rd_i     (cpu_rd_i),
   .rank_valid_o (rank_valid_o),
   .cpu_valid_o  (cpu_valid_o)
);

//--- bench/wrr_tb.sv
`timescale 1ns/1ps

module wrr_tb;

   localparam int unsigned MAX_ROUND = 7;   // Small so the epoch wraps quickly
   localparam int MAX_LINES = 64;

   logic               clk_cp = 1'b0;
   logic               rst;
   logic               pkt_valid_i;
   wrr_pkg::port_map_t pkt_port_i;
   wrr_pkg::class_t    pkt_class_i;
   logic               dq_valid_i;
   wrr_pkg::port_id_t  dq_port_i;
   wrr_pkg::round_t    dq_round_i;
   wrr_pkg::ovf_t      dq_ovf_i;
   logic               cpu_wr_i;
   wrr_pkg::flow_id_t  cpu_wr_idx_i;
   wrr_pkg::weight_t   cpu_wr_weight_i;
   logic               cpu_rd_i;
   wrr_pkg::flow_id_t  cpu_rd_idx_i;
   logic               rank_valid_o;
   wrr_pkg::rank_t     rank_o;
   logic               cpu_valid_o;
   wrr_pkg::flow_id_t  cpu_idx_o;
   wrr_pkg::cpu_val_t  cpu_val_o;

   // Pattern lines
   logic [7:0]  op_l   [MAX_LINES];
   int          test_l [MAX_LINES];
   logic [31:0] a_l [MAX_LINES], b_l [MAX_LINES], c_l [MAX_LINES];
   logic [31:0] d_l [MAX_LINES], e_l [MAX_LINES], exp_l [MAX_LINES];
   int          num_lines;
   int          cycles;
   int          cycle_limit;

   // Reference model of the flow table
   wrr_pkg::round_t  m_round  [wrr_pkg::NUM_FLOWS];
   wrr_pkg::ovf_t    m_ovf    [wrr_pkg::NUM_FLOWS];
   wrr_pkg::weight_t m_weight [wrr_pkg::NUM_FLOWS];
   wrr_pkg::weight_t m_cfg    [wrr_pkg::NUM_FLOWS];

   // Results due one cycle after the drive
   logic              exp_rank_v, file_rank_v, exp_cpu_v, file_val_v;
   wrr_pkg::rank_t    exp_rank, file_rank;
   wrr_pkg::flow_id_t exp_idx;
   wrr_pkg::cpu_val_t exp_val, file_val;
   int                cur_test;
   int                rank_errs, cpu_errs, idx_errs, proto_errs;

   wrr_top #(.MAX_ROUND (MAX_ROUND)) wrr_top_inst
   (
      .clk_cp (clk_cp), .rst (rst),
      .pkt_valid_i (pkt_valid_i), .pkt_port_i (pkt_port_i), .pkt_class_i (pkt_class_i),
      .dq_valid_i (dq_valid_i), .dq_port_i (dq_port_i),
      .dq_round_i (dq_round_i), .dq_ovf_i (dq_ovf_i),
      .cpu_wr_i (cpu_wr_i), .cpu_wr_idx_i (cpu_wr_idx_i), .cpu_wr_weight_i (cpu_wr_weight_i),
      .cpu_rd_i (cpu_rd_i), .cpu_rd_idx_i (cpu_rd_idx_i),
      .rank_valid_o (rank_valid_o), .rank_o (rank_o),
      .cpu_valid_o (cpu_valid_o), .cpu_idx_o (cpu_idx_o), .cpu_val_o (cpu_val_o)
   );

   always #4 clk_cp = ~clk_cp;   // 8 ns period

   always @(posedge clk_cp)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, the pattern run did not finish", cycles);
         $display("tests failed");
         $finish;
      end
   end

   function automatic string test_name(input int n);
      case (n)
         1:       return "reset defaults";
         2:       return "weighted round steps";
         3:       return "overflow wrap";
         4:       return "port decode";
         5:       return "dequeue catch-up";
         6:       return "write priority";
         default: return "unknown test";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic wrr_pkg::port_id_t port_of(input wrr_pkg::port_map_t map);
      case (map)
         8'h01:   return 3'd0;
         8'h04:   return 3'd1;
         8'h10:   return 3'd2;
         8'h40:   return 3'd3;
         default: return 3'd4;   // Anything else is the DMA/CPU port
      endcase
   endfunction

   function automatic bit is_later(input wrr_pkg::ovf_t fb_ovf, input wrr_pkg::round_t fb_round,
                                   input wrr_pkg::ovf_t ovf, input wrr_pkg::round_t round);
      return (fb_ovf > ovf) || (fb_ovf == 2'd0 && ovf == 2'd3)
             || (fb_ovf == ovf && fb_round > round);
   endfunction

   task automatic model_feedback(input int port, input wrr_pkg::round_t round,
                                 input wrr_pkg::ovf_t ovf);
      int f;
      for (int c = 0; c < wrr_pkg::NUM_CLASSES; c++)
      begin
         f = port * wrr_pkg::NUM_CLASSES + c;
         if (is_later(ovf, round, m_ovf[f], m_round[f]))
         begin
            m_round[f]  = round;
            m_ovf[f]    = ovf;
            m_weight[f] = 8'd0;
         end
      end
   endtask

   task automatic model_packet(input wrr_pkg::flow_id_t flow, output wrr_pkg::rank_t rank);
      if (m_weight[flow] < m_cfg[flow])
         m_weight[flow] = m_weight[flow] + 8'd1;
      else
      begin
         m_weight[flow] = 8'd1;
         if (m_round[flow] < MAX_ROUND)
            m_round[flow] = m_round[flow] + 11'd1;
         else
         begin
            m_round[flow] = 11'd1;
            m_ovf[flow]   = m_ovf[flow] + 2'd1;   // Wraps 3 to 0
         end
      end
      rank = {m_ovf[flow], m_round[flow], flow[4:0]};
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_rank(input string name, input wrr_pkg::rank_t expected,
                             input wrr_pkg::rank_t actual);
      if (actual !== expected)
      begin
         rank_errs++;
         $display("[ERROR] %s: rank expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_cpu(input string name, input wrr_pkg::cpu_val_t expected,
                            input wrr_pkg::cpu_val_t actual);
      if (actual !== expected)
      begin
         cpu_errs++;
         $display("[ERROR] %s: CPU value expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_idx(input string name, input wrr_pkg::flow_id_t expected,
                            input wrr_pkg::flow_id_t actual);
      if (actual !== expected)
      begin
         idx_errs++;
         $display("[ERROR] %s: CPU index expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_results();
      string name;
      name = test_name(cur_test);
      if (rank_valid_o !== exp_rank_v)
      begin
         proto_errs++;
         $display("In test %s the rank valid was %b when %b was due", name, rank_valid_o,
                  exp_rank_v);
      end
      else if (exp_rank_v)
      begin
         check_rank(name, exp_rank, rank_o);
         if (file_rank_v)
            check_rank({name, " (pattern file)"}, file_rank, rank_o);
      end
      if (cpu_valid_o !== exp_cpu_v)
      begin
         proto_errs++;
         $display("In test %s the CPU valid was %b when %b was due", name, cpu_valid_o,
                  exp_cpu_v);
      end
      else if (exp_cpu_v)
      begin
         check_idx(name, exp_idx, cpu_idx_o);
         check_cpu(name, exp_val, cpu_val_o);
         if (file_val_v)
            check_cpu({name, " (pattern file)"}, file_val, cpu_val_o);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   task automatic drive_idle();
      pkt_valid_i = 1'b0;
      pkt_port_i  = '0;
      pkt_class_i = '0;
      dq_valid_i  = 1'b0;
      dq_port_i   = '0;
      dq_round_i  = '0;
      dq_ovf_i    = '0;
      cpu_wr_i    = 1'b0;
      cpu_wr_idx_i    = '0;
      cpu_wr_weight_i = '0;
      cpu_rd_i     = 1'b0;
      cpu_rd_idx_i = '0;
      exp_rank_v  = 1'b0;
      file_rank_v = 1'b0;
      exp_cpu_v   = 1'b0;
      file_val_v  = 1'b0;
   endtask

   task automatic drive_op(input int i);
      logic [7:0]        op;
      wrr_pkg::class_t   cls;
      wrr_pkg::flow_id_t idx;
      op = op_l[i];
      idx = a_l[i][7:0];
      drive_idle();
      cur_test = test_l[i];
      case (op)
         "P", "N", "Q":
         begin
            cls = (op == "N" && d_l[i] != 0) ? wrr_pkg::class_t'($urandom) : b_l[i][4:0];
            if (op == "Q")
            begin
               dq_valid_i = 1'b1;   // Feedback lands in the same cycle
               dq_port_i  = c_l[i][2:0];
               dq_round_i = d_l[i][10:0];
               dq_ovf_i   = e_l[i][1:0];
               model_feedback(dq_port_i, dq_round_i, dq_ovf_i);
            end
            pkt_valid_i = 1'b1;
            pkt_port_i  = a_l[i][7:0];
            pkt_class_i = cls;
            model_packet({port_of(pkt_port_i), cls}, exp_rank);
            exp_rank_v  = 1'b1;
            file_rank_v = (op != "N");
            file_rank   = exp_l[i][17:0];
         end
         "F":
         begin
            dq_valid_i = 1'b1;
            dq_port_i  = a_l[i][2:0];
            dq_round_i = b_l[i][10:0];
            dq_ovf_i   = c_l[i][1:0];
            model_feedback(dq_port_i, dq_round_i, dq_ovf_i);
         end
         "W", "B":
         begin
            cpu_wr_i        = 1'b1;
            cpu_wr_idx_i    = idx;
            cpu_wr_weight_i = b_l[i][7:0];
            if (op == "B")
            begin
               cpu_rd_i     = 1'b1;
               cpu_rd_idx_i = c_l[i][7:0];
            end
            m_cfg[idx] = b_l[i][7:0];
            exp_cpu_v  = 1'b1;
            exp_idx    = idx;
            exp_val    = 29'd0;   // Acknowledge only
            file_val_v = 1'b1;
            file_val   = exp_l[i][28:0];
         end
         "R":
         begin
            cpu_rd_i     = 1'b1;
            cpu_rd_idx_i = idx;
            exp_cpu_v    = 1'b1;
            exp_idx      = idx;
            exp_val = {m_ovf[idx], m_round[idx], m_cfg[idx], m_weight[idx]};
            file_val_v   = 1'b1;
            file_val     = exp_l[i][28:0];
         end
         default:
         begin
            proto_errs++;
            $display("Pattern line %0d has an unknown operation and was skipped", i);
         end
      endcase
   endtask

   task automatic load_patterns();
      int          fd;
      int          n;
      int          tst;
      string       line;
      logic [7:0]  op;
      logic [31:0] a, b, c, d, e, x;
      num_lines   = 0;
      cycle_limit = 50;
      fd = $fopen("bench/wrr_patterns.txt", "r");
      if (fd == 0)
      begin
         proto_errs++;
         $display("Could not open the pattern file bench/wrr_patterns.txt");
      end
      else
      begin
         while (!$feof(fd) && num_lines < MAX_LINES)
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#")
            begin
               n = $sscanf(line, "%c %d %h %h %h %h %h %h", op, tst, a, b, c, d, e, x);
               if (n == 8)
               begin
                  op_l[num_lines]   = op;
                  test_l[num_lines] = tst;
                  a_l[num_lines]    = a;
                  b_l[num_lines]    = b;
                  c_l[num_lines]    = c;
                  d_l[num_lines]    = d;
                  e_l[num_lines]    = e;
                  exp_l[num_lines]  = x;
                  cycle_limit += 2 * ((op == "N") ? int'(c) : 1);
                  num_lines++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial
   begin
      int reps;
      int assert_errs;
      void'($urandom(32'h18d9_f5cb));
      cycles      = 0;
      cycle_limit = 32'h7fff_ffff;
      rank_errs   = 0;
      cpu_errs    = 0;
      idx_errs    = 0;
      proto_errs  = 0;
      cur_test = 1;
      rst = 1'b0;
      drive_idle();
      for (int f = 0; f < wrr_pkg::NUM_FLOWS; f++)
      begin
         m_round[f]  = '0;
         m_ovf[f]    = '0;
         m_weight[f] = '0;
         m_cfg[f]    = 8'd1;
      end
      load_patterns();
      repeat (3) @(negedge clk_cp);
      rst = 1'b1;
      for (int i = 0; i < num_lines; i++)
      begin
         reps = (op_l[i] == "N") ? int'(c_l[i]) : 1;
         for (int r = 0; r < reps; r++)
         begin
            @(negedge clk_cp);
            check_results();
            drive_op(i);
         end
      end
      @(negedge clk_cp);
      check_results();
      drive_idle();
      @(negedge clk_cp);
      check_results();
      assert_errs = wrr_top_inst.props_inst.fail_count;
      $display("Errors: rank %0d, CPU value %0d, CPU index %0d, protocol %0d, assertion %0d",
               rank_errs, cpu_errs, idx_errs, proto_errs, assert_errs);
      if (rank_errs + cpu_errs + idx_errs + proto_errs + assert_errs == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- flist.f
src/wrr_pkg.sv
src/wrr_flow_table.sv
src/wrr_rank_calc.sv
src/wrr_weight_cfg.sv
src/wrr_top.sv
bench/wrr_props.sv
bench/wrr_tb.sv

//--- src/wrr_flow_table.sv
`timescale 1ns/1ps

module wrr_flow_table
(
   input  logic              clk_cp,
   input  logic              rst,
   // Dequeue feedback
   input  logic              dq_valid_i,
   input  wrr_pkg::port_id_t dq_port_i,
   input  wrr_pkg::round_t   dq_round_i,
   input  wrr_pkg::ovf_t     dq_ovf_i,
   // Packet flow and its write-back
   input  wrr_pkg::flow_id_t pkt_flow_i,
   input  logic              wr_en_i,
   input  wrr_pkg::round_t   wr_round_i,
   input  wrr_pkg::ovf_t     wr_ovf_i,
   input  wrr_pkg::weight_t  wr_weight_i,
   // CPU read flow
   input  wrr_pkg::flow_id_t rd_flow_i,
   output wrr_pkg::round_t   cur_round_o,
   output wrr_pkg::ovf_t     cur_ovf_o,
   output wrr_pkg::weight_t  cur_weight_o,
   output wrr_pkg::round_t   rd_round_o,
   output wrr_pkg::ovf_t     rd_ovf_o,
   output wrr_pkg::weight_t  rd_weight_o
);

   wrr_pkg::round_t  round_q  [wrr_pkg::NUM_FLOWS];
   wrr_pkg::ovf_t    ovf_q    [wrr_pkg::NUM_FLOWS];
   wrr_pkg::weight_t weight_q [wrr_pkg::NUM_FLOWS];

   logic pkt_port_hit;
   logic pkt_catch_up;

   // True when the dequeued epoch is ahead of the flow
   function automatic logic fb_later(input wrr_pkg::ovf_t   cur_ovf,
                                     input wrr_pkg::round_t cur_round);
      logic ovf_ahead;
      ovf_ahead = (dq_ovf_i > cur_ovf) || (dq_ovf_i == 2'd0 && cur_ovf == 2'd3);
      return ovf_ahead || (dq_ovf_i == cur_ovf && dq_round_i > cur_round);
   endfunction

   ////////////////////////////////////////////////////////////
   // Packet flow view after catch-up
   ////////////////////////////////////////////////////////////

   assign pkt_port_hit = dq_valid_i && (pkt_flow_i[7:5] == dq_port_i);
   assign pkt_catch_up = pkt_port_hit && fb_later(ovf_q[pkt_flow_i], round_q[pkt_flow_i]);

   always_comb
   begin
      if (pkt_catch_up)
      begin
         cur_round_o  = dq_round_i;
         cur_ovf_o    = dq_ovf_i;
         cur_weight_o = '0;   // Restart the weight count in the new round
      end
      else
      begin
         cur_round_o  = round_q[pkt_flow_i];
         cur_ovf_o    = ovf_q[pkt_flow_i];
         cur_weight_o = weight_q[pkt_flow_i];
      end
   end

   // CPU read port sees stored state only
   always_comb
   begin
      if (rd_flow_i < wrr_pkg::FLOW_ID_W'(wrr_pkg::NUM_FLOWS))
      begin
         rd_round_o  = round_q[rd_flow_i];
         rd_ovf_o    = ovf_q[rd_flow_i];
         rd_weight_o = weight_q[rd_flow_i];
      end
      else
      begin
         rd_round_o  = '0;   // Index past the last flow
         rd_ovf_o    = '0;
         rd_weight_o = '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // State update
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         for (int f = 0; f < wrr_pkg::NUM_FLOWS; f++)
         begin
            round_q[f]  <= '0;
            ovf_q[f]    <= '0;
            weight_q[f] <= '0;
         end
      end
      else
      begin
         for (int f = 0; f < wrr_pkg::NUM_FLOWS; f++)
         begin
            if (wr_en_i && pkt_flow_i == wrr_pkg::flow_id_t'(f))
            begin
               // Packet step already includes any catch-up
               round_q[f]  <= wr_round_i;
               ovf_q[f]    <= wr_ovf_i;
               weight_q[f] <= wr_weight_i;
            end
            else if (dq_valid_i && dq_port_i == wrr_pkg::port_id_t'(f / wrr_pkg::NUM_CLASSES)
                     && fb_later(ovf_q[f], round_q[f]))
            begin
               round_q[f]  <= dq_round_i;   // Pull lagging flow forward
               ovf_q[f]    <= dq_ovf_i;
               weight_q[f] <= '0;
            end
         end
      end
   end

endmodule

//--- src/wrr_pkg.sv
package wrr_pkg;

   ////////////////////////////////////////////////////////////
   // Table geometry
   ////////////////////////////////////////////////////////////

   localparam int NUM_PORTS   = 5;      // nf0..nf3 and DMA/CPU
   localparam int NUM_CLASSES = 32;     // Classes per port
   localparam int NUM_FLOWS   = NUM_PORTS * NUM_CLASSES;

   ////////////////////////////////////////////////////////////
   // Field widths
   ////////////////////////////////////////////////////////////

   localparam int PORT_MAP_W = 8;
   localparam int PORT_ID_W  = 3;
   localparam int CLASS_W    = 5;
   localparam int FLOW_ID_W  = PORT_ID_W + CLASS_W;
   localparam int ROUND_W    = 11;
   localparam int OVF_W      = 2;
   localparam int WEIGHT_W   = 8;

   // Rank is overflow, round, class from high to low
   localparam int RANK_W    = OVF_W + ROUND_W + CLASS_W;
   // Read-back is overflow, round, configured weight, weight
   localparam int CPU_VAL_W = OVF_W + ROUND_W + 2 * WEIGHT_W;

   typedef logic [PORT_MAP_W-1:0] port_map_t;   // One-hot ingress port
   typedef logic [PORT_ID_W-1:0]  port_id_t;
   typedef logic [CLASS_W-1:0]    class_t;
   typedef logic [FLOW_ID_W-1:0]  flow_id_t;    // {port id, class}
   typedef logic [ROUND_W-1:0]    round_t;
   typedef logic [OVF_W-1:0]      ovf_t;        // Wraps modulo 4
   typedef logic [WEIGHT_W-1:0]   weight_t;
   typedef logic [RANK_W-1:0]     rank_t;
   typedef logic [CPU_VAL_W-1:0]  cpu_val_t;

endpackage

//--- src/wrr_rank_calc.sv
`timescale 1ns/1ps

module wrr_rank_calc
#(
   parameter int unsigned MAX_ROUND = 2047
)
(
   input  logic               clk_cp,
   input  logic               rst,
   input  logic               pkt_valid_i,
   input  wrr_pkg::port_map_t pkt_port_i,
   input  wrr_pkg::class_t    pkt_class_i,
   // Caught-up state of the packet flow
   input  wrr_pkg::round_t    cur_round_i,
   input  wrr_pkg::ovf_t      cur_ovf_i,
   input  wrr_pkg::weight_t   cur_weight_i,
   input  wrr_pkg::weight_t   cfg_weight_i,
   output wrr_pkg::flow_id_t  pkt_flow_o,
   output logic               wr_en_o,
   output wrr_pkg::round_t    wr_round_o,
   output wrr_pkg::ovf_t      wr_ovf_o,
   output wrr_pkg::weight_t   wr_weight_o,
   output logic               rank_valid_o,
   output wrr_pkg::rank_t     rank_o
);

   localparam wrr_pkg::round_t ROUND_LAST = wrr_pkg::round_t'(MAX_ROUND);

   wrr_pkg::port_id_t port_id;
   logic              rank_valid_q;
   wrr_pkg::rank_t    rank_q;

   ////////////////////////////////////////////////////////////
   // Port decode
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (pkt_port_i)
         8'h01:   port_id = 3'd0;
         8'h04:   port_id = 3'd1;
         8'h10:   port_id = 3'd2;
         8'h40:   port_id = 3'd3;
         default: port_id = wrr_pkg::port_id_t'(wrr_pkg::NUM_PORTS - 1);   // DMA/CPU port
      endcase
   end

   assign pkt_flow_o = {port_id, pkt_class_i};

   ////////////////////////////////////////////////////////////
   // WRR step
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      wr_round_o  = cur_round_i;
      wr_ovf_o    = cur_ovf_i;
      wr_weight_o = cur_weight_i + 8'd1;
      if (cur_weight_i >= cfg_weight_i)
      begin
         // Weight used up so move to the next round
         wr_weight_o = 8'd1;
         if (cur_round_i < ROUND_LAST)
         begin
            wr_round_o = cur_round_i + 11'd1;
         end
         else
         begin
            wr_round_o = 11'd1;
            wr_ovf_o   = cur_ovf_i + 2'd1;   // Epoch wraps mod 4
         end
      end
   end

   assign wr_en_o = pkt_valid_i;

   // Rank register
   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         rank_valid_q <= 1'b0;
         rank_q       <= '0;
      end
      else
      begin
         rank_valid_q <= pkt_valid_i;
         if (pkt_valid_i)
            rank_q <= {wr_ovf_o, wr_round_o, pkt_class_i};
      end
   end

   assign rank_valid_o = rank_valid_q;
   assign rank_o       = rank_q;

endmodule

//--- src/wrr_top.sv
`timescale 1ns/1ps

module wrr_top
#(
   parameter int unsigned MAX_ROUND = 2047
)
(
   input  logic               clk_cp,
   input  logic               rst,
   // Packet descriptors
   input  logic               pkt_valid_i,
   input  wrr_pkg::port_map_t pkt_port_i,
   input  wrr_pkg::class_t    pkt_class_i,
   // Scheduler dequeue feedback
   input  logic               dq_valid_i,
   input  wrr_pkg::port_id_t  dq_port_i,
   input  wrr_pkg::round_t    dq_round_i,
   input  wrr_pkg::ovf_t      dq_ovf_i,
   // CPU channel
   input  logic               cpu_wr_i,
   input  wrr_pkg::flow_id_t  cpu_wr_idx_i,
   input  wrr_pkg::weight_t   cpu_wr_weight_i,
   input  logic               cpu_rd_i,
   input  wrr_pkg::flow_id_t  cpu_rd_idx_i,
   output logic               rank_valid_o,
   output wrr_pkg::rank_t     rank_o,
   output logic               cpu_valid_o,
   output wrr_pkg::flow_id_t  cpu_idx_o,
   output wrr_pkg::cpu_val_t  cpu_val_o
);

   wrr_pkg::flow_id_t pkt_flow;
   logic              wr_en;
   wrr_pkg::round_t   wr_round;
   wrr_pkg::ovf_t     wr_ovf;
   wrr_pkg::weight_t  wr_weight;
   wrr_pkg::round_t   cur_round;
   wrr_pkg::ovf_t     cur_ovf;
   wrr_pkg::weight_t  cur_weight;
   wrr_pkg::round_t   rd_round;
   wrr_pkg::ovf_t     rd_ovf;
   wrr_pkg::weight_t  rd_weight;
   wrr_pkg::weight_t  cfg_weight;

   ////////////////////////////////////////////////////////////
   // Flow state storage
   ////////////////////////////////////////////////////////////

   wrr_flow_table flow_table_inst
   (
      .clk_cp       (clk_cp),
      .rst          (rst),
      .dq_valid_i   (dq_valid_i),
      .dq_port_i    (dq_port_i),
      .dq_round_i   (dq_round_i),
      .dq_ovf_i     (dq_ovf_i),
      .pkt_flow_i   (pkt_flow),
      .wr_en_i      (wr_en),
      .wr_round_i   (wr_round),
      .wr_ovf_i     (wr_ovf),
      .wr_weight_i  (wr_weight),
      .rd_flow_i    (cpu_rd_idx_i),   // CPU read index addresses the table directly
      .cur_round_o  (cur_round),
      .cur_ovf_o    (cur_ovf),
      .cur_weight_o (cur_weight),
      .rd_round_o   (rd_round),
      .rd_ovf_o     (rd_ovf),
      .rd_weight_o  (rd_weight)
   );

   wrr_rank_calc
   #(
      .MAX_ROUND (MAX_ROUND)
   )
   rank_calc_inst
   (
      .clk_cp       (clk_cp),
      .rst          (rst),
      .pkt_valid_i  (pkt_valid_i),
      .pkt_port_i   (pkt_port_i),
      .pkt_class_i  (pkt_class_i),
      .cur_round_i  (cur_round),
      .cur_ovf_i    (cur_ovf),
      .cur_weight_i (cur_weight),
      .cfg_weight_i (cfg_weight),
      .pkt_flow_o   (pkt_flow),
      .wr_en_o      (wr_en),
      .wr_round_o   (wr_round),
      .wr_ovf_o     (wr_ovf),
      .wr_weight_o  (wr_weight),
      .rank_valid_o (rank_valid_o),
      .rank_o       (rank_o)
   );

   // Configured weights and CPU response
   wrr_weight_cfg weight_cfg_inst
   (
      .clk_cp          (clk_cp),
      .rst             (rst),
      .cpu_wr_i        (cpu_wr_i),
      .cpu_wr_idx_i    (cpu_wr_idx_i),
      .cpu_wr_weight_i (cpu_wr_weight_i),
      .cpu_rd_i        (cpu_rd_i),
      .cpu_rd_idx_i    (cpu_rd_idx_i),
      .pkt_flow_i      (pkt_flow),
      .rd_round_i      (rd_round),
      .rd_ovf_i        (rd_ovf),
      .rd_weight_i     (rd_weight),
      .cfg_weight_o    (cfg_weight),
      .cpu_valid_o     (cpu_valid_o),
      .cpu_idx_o       (cpu_idx_o),
      .cpu_val_o       (cpu_val_o)
   );

endmodule

//--- src/wrr_weight_cfg.sv
`timescale 1ns/1ps

module wrr_weight_cfg
(
   input  logic              clk_cp,
   input  logic              rst,
   // CPU channel
   input  logic              cpu_wr_i,
   input  wrr_pkg::flow_id_t cpu_wr_idx_i,
   input  wrr_pkg::weight_t  cpu_wr_weight_i,
   input  logic              cpu_rd_i,
   input  wrr_pkg::flow_id_t cpu_rd_idx_i,
   // Packet flow lookup
   input  wrr_pkg::flow_id_t pkt_flow_i,
   // Stored state of the read flow
   input  wrr_pkg::round_t   rd_round_i,
   input  wrr_pkg::ovf_t     rd_ovf_i,
   input  wrr_pkg::weight_t  rd_weight_i,
   output wrr_pkg::weight_t  cfg_weight_o,
   output logic              cpu_valid_o,
   output wrr_pkg::flow_id_t cpu_idx_o,
   output wrr_pkg::cpu_val_t cpu_val_o
);

   localparam wrr_pkg::flow_id_t FLOW_END = wrr_pkg::flow_id_t'(wrr_pkg::NUM_FLOWS);

   wrr_pkg::weight_t  cfg_q [wrr_pkg::NUM_FLOWS];
   wrr_pkg::weight_t  rd_cfg;
   logic              cpu_valid_q;
   wrr_pkg::flow_id_t cpu_idx_q;
   wrr_pkg::cpu_val_t cpu_val_q;

   assign cfg_weight_o = cfg_q[pkt_flow_i];
   assign rd_cfg       = (cpu_rd_idx_i < FLOW_END) ? cfg_q[cpu_rd_idx_i] : '0;

   ////////////////////////////////////////////////////////////
   // Configured weight table
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         for (int f = 0; f < wrr_pkg::NUM_FLOWS; f++)
            cfg_q[f] <= 8'd1;   // One packet per round by default
      end
      else if (cpu_wr_i && cpu_wr_idx_i < FLOW_END)
      begin
         cfg_q[cpu_wr_idx_i] <= cpu_wr_weight_i;
      end
   end

   // Response register where a write wins over a read
   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         cpu_valid_q <= 1'b0;
         cpu_idx_q   <= '0;
         cpu_val_q   <= '0;
      end
      else
      begin
         cpu_valid_q <= cpu_wr_i || cpu_rd_i;
         if (cpu_wr_i)
         begin
            cpu_idx_q <= cpu_wr_idx_i;
            cpu_val_q <= '0;   // Plain acknowledge
         end
         else if (cpu_rd_i)
         begin
            cpu_idx_q <= cpu_rd_idx_i;
            cpu_val_q <= {rd_ovf_i, rd_round_i, rd_cfg, rd_weight_i};
         end
      end
   end

   assign cpu_valid_o = cpu_valid_q;
   assign cpu_idx_o   = cpu_idx_q;
   assign cpu_val_o   = cpu_val_q;

endmodule
